// ==== project.f ====
source/control_pkg.sv
source/fifo_pkg.sv
source/sync_fifo.sv
source/rr_bus_arbiter.sv
source/control_request_arbiter.sv
verif/tb_clock_gen.sv
verif/control_arbiter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module control_arbiter_tb \
  -f project.f \
  --Mdir obj_dir -o control_arbiter_sim \
  || { echo "run_sim: build error"; exit 1; }

./obj_dir/control_arbiter_sim | tee /dev/stderr | grep -x "TESTBENCH PASSED" > /dev/null \
  && echo "run_sim: simulation ok" \
  || { echo "run_sim: simulation did not pass"; exit 1; }

// ==== source/control_pkg.sv ====
// --------------------------------------
// Control packet definitions
//   Requestor count
//   Vertex, command and source id types
//   Payload and packet structs
// --------------------------------------

package control_pkg;

  // --------------------------------------
  // Sizing
  // --------------------------------------
  // Engine lanes feeding the funnel
  localparam int NUM_REQUESTOR = 2;

  localparam int VERTEX_ID_W = 32;
  localparam int CMD_W       = 3;
  // Enough bits to name any requestor
  localparam int SRC_ID_W    = (NUM_REQUESTOR > 1) ? $clog2(NUM_REQUESTOR) : 1;

  // --------------------------------------
  // Field types
  // --------------------------------------
  // Target graph vertex
  typedef logic [VERTEX_ID_W-1:0] vertex_id_t;
  // Command code
  typedef logic [CMD_W-1:0]       cmd_t;
  // Index of the granted requestor
  typedef logic [SRC_ID_W-1:0]    src_id_t;

  // --------------------------------------
  // Packet structs
  // --------------------------------------
  // Queue data word
  typedef struct packed {
    vertex_id_t vertex_id;
    cmd_t       cmd;
    src_id_t    src_id;
  } control_payload_t;

  // Payload qualified by a valid bit
  typedef struct packed {
    logic             valid;
    control_payload_t payload;
  } control_packet_t;

endpackage : control_pkg

// ==== source/control_request_arbiter.sv ====
// --------------------------------------
// Control request funnel, top level
//   Input registers and per-lane queues
//   Round-robin merge into output queue
//   Registered grants, status and setup
// --------------------------------------

`timescale 1ns/100ps

module control_request_arbiter (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  control_pkg::control_packet_t          request_in [control_pkg::NUM_REQUESTOR],
  input  fifo_pkg::fifo_ctrl_t                  fifo_ctrl_in,
  output fifo_pkg::fifo_out_status_t            fifo_status_out,
  output logic [control_pkg::NUM_REQUESTOR-1:0] grant_out,
  output control_pkg::control_packet_t          request_out,
  output logic                                  fifo_setup
);

  // --------------------------------------
  // Signals
  // --------------------------------------
  // Registered inputs
  control_pkg::control_packet_t request_in_reg [control_pkg::NUM_REQUESTOR];
  logic                         rd_en_reg;

  // Input queues
  control_pkg::control_payload_t         in_dout   [control_pkg::NUM_REQUESTOR];
  fifo_pkg::fifo_ctrl_t                  in_ctrl   [control_pkg::NUM_REQUESTOR];
  fifo_pkg::fifo_status_t                in_status [control_pkg::NUM_REQUESTOR];
  logic [control_pkg::NUM_REQUESTOR-1:0] in_busy;

  // Arbiter
  control_pkg::control_packet_t          arb_bus_in [control_pkg::NUM_REQUESTOR];
  logic [control_pkg::NUM_REQUESTOR-1:0] arb_req;
  logic [control_pkg::NUM_REQUESTOR-1:0] arb_grant;
  control_pkg::control_packet_t          arb_bus_out;

  // Output queue
  control_pkg::control_packet_t  out_din_reg;
  fifo_pkg::fifo_ctrl_t          out_ctrl;
  fifo_pkg::fifo_status_t        out_status;
  control_pkg::control_payload_t out_dout;

  // --------------------------------------
  // Input registers
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_en_reg <= 1'b0;
      for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
        request_in_reg[i].valid <= 1'b0;
      end
    end else begin
      // Consumer only drives rd_en
      rd_en_reg <= fifo_ctrl_in.rd_en;
      for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
        request_in_reg[i].valid <= request_in[i].valid;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
      request_in_reg[i].payload <= request_in[i].payload;
    end
  end

  // --------------------------------------
  // Per-requestor input queues
  // --------------------------------------
  for (genvar i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin : gen_in_queue
    // Push on every registered valid
    assign in_ctrl[i].wr_en = request_in_reg[i].valid;
    // Pop when granted and holding data
    assign in_ctrl[i].rd_en = ~in_status[i].empty & arb_grant[i];
    assign in_busy[i]       = in_status[i].rst_busy;

    // Queue head toward the arbiter
    assign arb_req[i]            = ~in_status[i].empty;
    assign arb_bus_in[i].valid   = in_status[i].valid;
    assign arb_bus_in[i].payload = in_dout[i];

    sync_fifo #(
      .DEPTH      (fifo_pkg::IN_FIFO_DEPTH),
      .PROG_THRESH(fifo_pkg::IN_PROG_THRESH)
    ) in_fifo_i (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .din           (request_in_reg[i].payload),
      .ctrl          (in_ctrl[i]),
      .dout          (in_dout[i]),
      .status        (in_status[i])
    );
  end

  // Merge the queue heads
  rr_bus_arbiter rr_bus_arbiter_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req           (arb_req),
    .bus_in        (arb_bus_in),
    .grant         (arb_grant),
    .bus_out       (arb_bus_out)
  );

  // --------------------------------------
  // Output queue
  // --------------------------------------
  // Stamped packet staged one cycle before the push
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_din_reg.valid <= 1'b0;
    end else begin
      out_din_reg.valid <= arb_bus_out.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_din_reg.payload <= arb_bus_out.payload;
  end

  assign out_ctrl.wr_en = out_din_reg.valid;
  assign out_ctrl.rd_en = ~out_status.empty & rd_en_reg;

  sync_fifo #(
    .DEPTH      (fifo_pkg::OUT_FIFO_DEPTH),
    .PROG_THRESH(fifo_pkg::OUT_PROG_THRESH)
  ) out_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (out_din_reg.payload),
    .ctrl          (out_ctrl),
    .dout          (out_dout),
    .status        (out_status)
  );

  // --------------------------------------
  // Output registers
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out.valid         <= 1'b0;
      fifo_status_out.empty     <= 1'b1;
      fifo_status_out.prog_full <= 1'b0;
      grant_out                 <= '0;
      fifo_setup                <= 1'b1;
    end else begin
      request_out.valid         <= out_status.valid;
      fifo_status_out.empty     <= out_status.empty;
      fifo_status_out.prog_full <= out_status.prog_full;
      // Any queue still coming out of reset
      fifo_setup                <= (|in_busy) | out_status.rst_busy;
      // Lane may send only while both its queue and the output have room
      for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
        grant_out[i] <= ~in_status[i].prog_full & ~out_status.prog_full;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    request_out.payload <= out_dout;
  end

endmodule : control_request_arbiter

// ==== source/fifo_pkg.sv ====
// --------------------------------------
// Queue definitions
//   Control and status structs
//   Depths and almost-full thresholds
//   Reset busy counter type
// --------------------------------------

package fifo_pkg;

  // Per-requestor input queues
  localparam int IN_FIFO_DEPTH   = 16;
  localparam int IN_PROG_THRESH  = 12;

  // Shared output queue
  localparam int OUT_FIFO_DEPTH  = 32;
  localparam int OUT_PROG_THRESH = 24;

  // Cycles of rst_busy after reset release
  localparam int RST_BUSY_CYCLES = 2;

  typedef logic [1:0] rst_cnt_t;

  // Push and pop strobes
  typedef struct packed {
    logic rd_en;
    logic wr_en;
  } fifo_ctrl_t;

  // Full status seen inside the funnel
  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic rst_busy;
  } fifo_status_t;

  // Subset reported to the consumer
  typedef struct packed {
    logic empty;
    logic prog_full;
  } fifo_out_status_t;

endpackage : fifo_pkg

// ==== source/rr_bus_arbiter.sv ====
// --------------------------------------
// Round-robin bus arbiter
//   Registered grant with hold cycle
//   Source stamping of the queue head
//   Registered bus output
// --------------------------------------

`timescale 1ns/100ps

module rr_bus_arbiter (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic [control_pkg::NUM_REQUESTOR-1:0] req,
  input  control_pkg::control_packet_t          bus_in [control_pkg::NUM_REQUESTOR],
  output logic [control_pkg::NUM_REQUESTOR-1:0] grant,
  output control_pkg::control_packet_t          bus_out
);

  // First index searched next round
  control_pkg::src_id_t prio_ptr;
  control_pkg::src_id_t grant_idx;
  control_pkg::src_id_t next_ptr;

  logic [control_pkg::NUM_REQUESTOR-1:0] grant_next;
  control_pkg::control_packet_t          bus_sel;

  // --------------------------------------
  // Grant search
  // --------------------------------------
  always_comb begin : grant_search
    int idx;
    grant_next = '0;
    grant_idx  = prio_ptr;
    // Walk from the priority pointer, first hit wins
    for (int k = 0; k < control_pkg::NUM_REQUESTOR; k++) begin
      idx = (int'(prio_ptr) + k) % control_pkg::NUM_REQUESTOR;
      if (req[idx] && (grant_next == '0)) begin
        grant_next[idx] = 1'b1;
        grant_idx       = control_pkg::src_id_t'(idx);
      end
    end
  end

  // Pointer moves past the winner, wraps at the top
  assign next_ptr = (int'(grant_idx) == control_pkg::NUM_REQUESTOR - 1) ?
                    '0 : grant_idx + 1'b1;

  // One grant, then one idle cycle while the read returns
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant    <= '0;
      prio_ptr <= '0;
    end else if (|grant) begin
      grant <= '0;
    end else begin
      grant <= grant_next;
      if (|grant_next) begin
        prio_ptr <= next_ptr;
      end
    end
  end

  // --------------------------------------
  // Bus select and stamp
  // --------------------------------------
  always_comb begin : bus_select
    bus_sel = '0;
    // At most one queue returns data in a cycle
    for (int k = 0; k < control_pkg::NUM_REQUESTOR; k++) begin
      if (bus_in[k].valid) begin
        bus_sel                = bus_in[k];
        bus_sel.payload.src_id = control_pkg::src_id_t'(k);
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out.valid <= 1'b0;
    end else begin
      bus_out.valid <= bus_sel.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    bus_out.payload <= bus_sel.payload;
  end

endmodule : rr_bus_arbiter

// ==== source/sync_fifo.sv ====
// --------------------------------------
// Synchronous FIFO
//   Circular buffer with occupancy count
//   Registered read data and valid
//   prog_full and reset busy status
// --------------------------------------

`timescale 1ns/100ps

module sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  control_pkg::control_payload_t din,
  input  fifo_pkg::fifo_ctrl_t          ctrl,
  output control_pkg::control_payload_t dout,
  output fifo_pkg::fifo_status_t        status
);

  // --------------------------------------
  // Storage and pointers
  // --------------------------------------
  control_pkg::control_payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  fifo_pkg::rst_cnt_t rst_cnt;
  logic               rst_busy;
  logic               full;
  logic               empty;
  logic               wr_fire;
  logic               rd_fire;
  logic               rd_valid;

  // Flags straight from the count
  assign full     = (int'(count) == DEPTH);
  assign empty    = (count == '0);
  assign rst_busy = (rst_cnt != '0);

  // Strobes dropped while busy or at the limits
  assign wr_fire = ctrl.wr_en & ~full & ~rst_busy;
  assign rd_fire = ctrl.rd_en & ~empty & ~rst_busy;

  // --------------------------------------
  // Reset busy window
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rst_cnt <= fifo_pkg::rst_cnt_t'(fifo_pkg::RST_BUSY_CYCLES);
    end else if (rst_busy) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Memory write, no reset on storage
  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= din;
    end
  end

  // Registered read port
  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_ptr];
    end
  end

  // Valid follows an accepted read by one cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_fire;
    end
  end

  // --------------------------------------
  // Status
  // --------------------------------------
  assign status.full      = full;
  assign status.empty     = empty;
  assign status.valid     = rd_valid;
  assign status.prog_full = (int'(count) >= PROG_THRESH);
  assign status.rst_busy  = rst_busy;

endmodule : sync_fifo

// ==== verif/control_arbiter_tb.sv ====
// --------------------------------------
// Testbench for the control request funnel
//   Clock generator and DUT
//   Reference model with per-lane queues
//   Output comparison and final report
// --------------------------------------

`timescale 1ns/100ps

module control_arbiter_tb;

  logic                                  ap_clk;
  logic                                  areset_control;
  control_pkg::control_packet_t          request_in [control_pkg::NUM_REQUESTOR];
  fifo_pkg::fifo_ctrl_t                  fifo_ctrl_in;
  fifo_pkg::fifo_out_status_t            fifo_status_out;
  logic [control_pkg::NUM_REQUESTOR-1:0] grant_out;
  control_pkg::control_packet_t          request_out;
  logic                                  fifo_setup;

  // Expected packets per lane
  control_pkg::control_payload_t exp_q [control_pkg::NUM_REQUESTOR][$];
  // Every delivered src_id in arrival order
  control_pkg::src_id_t          src_log [$];

  integer seed;
  // Consumer rd_en mode (0 low, 1 high, 2 random)
  int     rd_mode;

  // Output snapshots taken at the falling edge
  logic [control_pkg::NUM_REQUESTOR-1:0] grant_seen;
  fifo_pkg::fifo_out_status_t            status_seen;
  logic                                  setup_seen;

  int mismatches   = 0;
  int stray        = 0;
  int checked      = 0;
  int other_errors = 0;
  int log_start;
  int cycles;
  int total;
  logic [31:0] want_rnd;
  logic [control_pkg::NUM_REQUESTOR-1:0] sent_any;

  tb_clock_gen tb_clock_gen_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control)
  );

  control_request_arbiter control_request_arbiter_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .fifo_ctrl_in   (fifo_ctrl_in),
    .fifo_status_out(fifo_status_out),
    .grant_out      (grant_out),
    .request_out    (request_out),
    .fifo_setup     (fifo_setup)
  );

  // --------------------------------------
  // Reference model
  // --------------------------------------
  // Payload passes through with src_id set to the lane index
  function automatic control_pkg::control_payload_t expected_payload(
    input control_pkg::control_payload_t sent,
    input int                            lane
  );
    control_pkg::control_payload_t result;
    result        = sent;
    result.src_id = control_pkg::src_id_t'(lane);
    return result;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  // One clock of stimulus where a lane sends only if granted last cycle
  task automatic drive_cycle(
    input  logic [control_pkg::NUM_REQUESTOR-1:0] want,
    output logic [control_pkg::NUM_REQUESTOR-1:0] sent
  );
    control_pkg::control_packet_t pkt;
    logic [31:0]                  rnd;
    @(negedge ap_clk);
    grant_seen  = grant_out;
    status_seen = fifo_status_out;
    setup_seen  = fifo_setup;
    sent        = '0;
    @(posedge ap_clk);
    for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
      pkt = '0;
      if (want[i] && grant_seen[i]) begin
        pkt.valid             = 1'b1;
        pkt.payload.vertex_id = $random(seed);
        pkt.payload.cmd       = control_pkg::cmd_t'($random(seed));
        // Junk src_id that the DUT must overwrite
        pkt.payload.src_id    = control_pkg::src_id_t'($random(seed));
        exp_q[i].push_back(expected_payload(pkt.payload, i));
        sent[i] = 1'b1;
      end
      request_in[i] <= pkt;
    end
    rnd = $random(seed);
    // Random drain reads three cycles in four
    case (rd_mode)
      0:       fifo_ctrl_in.rd_en <= 1'b0;
      1:       fifo_ctrl_in.rd_en <= 1'b1;
      default: fifo_ctrl_in.rd_en <= (rnd[1:0] != 2'b00);
    endcase
  endtask

  task automatic send_burst(input int n0, input int n1);
    int left [control_pkg::NUM_REQUESTOR];
    logic [control_pkg::NUM_REQUESTOR-1:0] want;
    logic [control_pkg::NUM_REQUESTOR-1:0] sent;
    int count;
    left[0] = n0;
    left[1] = n1;
    count   = 0;
    while ((left[0] > 0 || left[1] > 0) && count < 400) begin
      for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
        want[i] = (left[i] > 0);
      end
      drive_cycle(want, sent);
      for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
        if (sent[i]) begin
          left[i]--;
        end
      end
      count++;
    end
    if (left[0] > 0 || left[1] > 0) begin
      $display("Timeout at %0t: burst stalled with %0d and %0d packets unsent",
               $time, left[0], left[1]);
      other_errors++;
    end
  endtask

  // Runs until every expected packet is out and the output queue is empty
  task automatic wait_drain();
    logic [control_pkg::NUM_REQUESTOR-1:0] sent;
    int count;
    count = 0;
    drive_cycle('0, sent);
    while ((outstanding() != 0 || !status_seen.empty) && count < 600) begin
      drive_cycle('0, sent);
      count++;
    end
    if (outstanding() != 0 || !status_seen.empty) begin
      $display("Timeout at %0t: %0d packets never came out of the DUT",
               $time, outstanding());
      other_errors++;
    end
  endtask

  task automatic wait_prog_full();
    logic [control_pkg::NUM_REQUESTOR-1:0] sent;
    int count;
    count = 0;
    drive_cycle('0, sent);
    while (!status_seen.prog_full && count < 200) begin
      drive_cycle('0, sent);
      count++;
    end
    if (!status_seen.prog_full) begin
      $display("Timeout at %0t: output queue never reported prog_full", $time);
      other_errors++;
    end else begin
      if (grant_seen !== '0) begin
        $display("Mismatch at %0t: grant_out got %b expected %b", $time, grant_seen, 2'b00);
        mismatches++;
      end
      // A queue past its threshold holds data
      if (status_seen.empty !== 1'b0) begin
        $display("Mismatch at %0t: fifo_status_out.empty got %b expected 0",
                 $time, status_seen.empty);
        mismatches++;
      end
    end
  endtask

  // --------------------------------------
  // Comparison process
  // --------------------------------------
  always @(negedge ap_clk) begin : compare_output
    control_pkg::control_payload_t expected;
    int                            src;
    if (!areset_control && request_out.valid) begin
      src = int'(request_out.payload.src_id);
      src_log.push_back(request_out.payload.src_id);
      if (exp_q[src].size() == 0) begin
        $display("Error at %0t: output from requestor %0d with nothing outstanding",
                 $time, src);
        stray++;
      end else begin
        expected = exp_q[src].pop_front();
        checked++;
        if (request_out.payload.vertex_id !== expected.vertex_id) begin
          $display("Mismatch at %0t: request_out.vertex_id got %h expected %h",
                   $time, request_out.payload.vertex_id, expected.vertex_id);
          mismatches++;
        end
        if (request_out.payload.cmd !== expected.cmd) begin
          $display("Mismatch at %0t: request_out.cmd got %0d expected %0d",
                   $time, request_out.payload.cmd, expected.cmd);
          mismatches++;
        end
        if (request_out.payload.src_id !== expected.src_id) begin
          $display("Mismatch at %0t: request_out.src_id got %0d expected %0d",
                   $time, request_out.payload.src_id, expected.src_id);
          mismatches++;
        end
      end
    end
  end

  // --------------------------------------
  // Stimulus sequence
  // --------------------------------------
  initial begin
    seed         = 32'h2faa;
    rd_mode      = 0;
    fifo_ctrl_in = '0;
    for (int i = 0; i < control_pkg::NUM_REQUESTOR; i++) begin
      request_in[i] = '0;
    end

    // Reset values and the fall of setup
    cycles = 0;
    @(negedge ap_clk);
    while (areset_control && cycles < 20) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (areset_control) begin
      $display("Timeout at %0t: reset never released", $time);
      other_errors++;
    end
    if (request_out.valid !== 1'b0) begin
      $display("Mismatch at %0t: request_out.valid got %b expected 0", $time, request_out.valid);
      mismatches++;
    end
    if (grant_out !== '0) begin
      $display("Mismatch at %0t: grant_out got %b expected 00", $time, grant_out);
      mismatches++;
    end
    if (fifo_setup !== 1'b1) begin
      $display("Mismatch at %0t: fifo_setup got %b expected 1", $time, fifo_setup);
      mismatches++;
    end
    cycles = 0;
    drive_cycle('0, sent_any);
    while (setup_seen && cycles < 10) begin
      drive_cycle('0, sent_any);
      cycles++;
    end
    if (setup_seen) begin
      $display("Timeout at %0t: fifo_setup stayed high", $time);
      other_errors++;
    end

    // One packet per lane in turn
    rd_mode = 1;
    send_burst(1, 0);
    wait_drain();
    send_burst(0, 1);
    wait_drain();

    // Equal bursts parked behind a stalled consumer
    rd_mode   = 0;
    log_start = src_log.size();
    send_burst(6, 6);
    rd_mode = 1;
    wait_drain();
    if (src_log.size() - log_start != 12) begin
      $display("Error at %0t: fairness burst delivered %0d packets instead of 12",
               $time, src_log.size() - log_start);
      other_errors++;
    end
    // Lane 0 leads and the lanes take turns
    for (int k = log_start; k < src_log.size(); k++) begin
      if (int'(src_log[k]) != (k - log_start) % control_pkg::NUM_REQUESTOR) begin
        $display("Mismatch at %0t: request_out.src_id at burst position %0d got %0d expected %0d",
                 $time, k - log_start, src_log[k], (k - log_start) % control_pkg::NUM_REQUESTOR);
        mismatches++;
      end
    end

    // Back-pressure with exactly one output queue worth of packets
    rd_mode = 0;
    send_burst(16, 16);
    wait_prog_full();
    rd_mode = 1;
    wait_drain();

    // Random traffic with a random consumer
    rd_mode = 2;
    repeat (300) begin
      want_rnd = $random(seed);
      drive_cycle(want_rnd[control_pkg::NUM_REQUESTOR-1:0], sent_any);
    end
    rd_mode = 1;
    wait_drain();

    total = mismatches + stray + other_errors;
    $display("Checked %0d packets: %0d mismatches, %0d unexpected, %0d other errors",
             checked, mismatches, stray, other_errors);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : control_arbiter_tb

// ==== verif/tb_clock_gen.sv ====
// --------------------------------------
// Testbench clock and reset
//   8 ns clock
//   Reset held for the first 3 edges
// --------------------------------------

`timescale 1ns/100ps

module tb_clock_gen (
  output logic ap_clk,
  output logic areset_control
);

  // Half of the 8 ns period
  localparam int HALF_PERIOD = 4;

  initial begin
    ap_clk = 1'b0;
    forever #(HALF_PERIOD) ap_clk = ~ap_clk;
  end

  // Released on the third rising edge
  initial begin
    areset_control = 1'b1;
    repeat (3) @(posedge ap_clk);
    areset_control <= 1'b0;
  end

endmodule : tb_clock_gen
